// File: hw/mipsPkg.sv
// mips core shared types and encodings
// instruction fields, opcode/funct values, ALU control and result select codes
package mipsPkg;

  typedef logic [31:0] word_t;    // data, address or instruction word
  typedef logic [4:0]  regAddr_t; // register number
  typedef logic [4:0]  shamt_t;   // shift amount field
  typedef logic [15:0] imm_t;     // immediate field
  typedef logic [5:0]  opcode_t;  // instr[31:26]
  typedef logic [5:0]  funct_t;   // instr[5:0]
  typedef logic [2:0]  aluCtrl_t; // base ALU operation
  typedef logic [1:0]  aluOp_t;   // main decoder to ALU decoding
  typedef logic [1:0]  aluExt_t;  // ALU result select

  // opcodes
  localparam opcode_t opRType = 6'b000000;
  localparam opcode_t opLw    = 6'b100011;
  localparam opcode_t opSw    = 6'b101011;
  localparam opcode_t opBeq   = 6'b000100;
  localparam opcode_t opBne   = 6'b000101;
  localparam opcode_t opAddi  = 6'b001000;
  localparam opcode_t opJ     = 6'b000010;
  localparam opcode_t opOri   = 6'b001101;
  localparam opcode_t opLui   = 6'b001111;

  // R-type funct codes
  localparam funct_t fnAdd  = 6'b100000;
  localparam funct_t fnSub  = 6'b100010;
  localparam funct_t fnAnd  = 6'b100100;
  localparam funct_t fnOr   = 6'b100101;
  localparam funct_t fnSlt  = 6'b101010;
  localparam funct_t fnSltu = 6'b101011;
  localparam funct_t fnXor  = 6'b100110;
  localparam funct_t fnSll  = 6'b000000; // shares value with nop

  // base ALU operations
  localparam aluCtrl_t aluAnd = 3'b000;
  localparam aluCtrl_t aluOr  = 3'b001;
  localparam aluCtrl_t aluAdd = 3'b010;
  localparam aluCtrl_t aluXor = 3'b011;
  localparam aluCtrl_t aluSub = 3'b110;
  localparam aluCtrl_t aluSlt = 3'b111;

  // ALU op classes from the main decoder
  localparam aluOp_t aopAdd   = 2'b00; // loads, stores, addi
  localparam aluOp_t aopSub   = 2'b01; // branch compare
  localparam aluOp_t aopFunct = 2'b10; // R-type, look at funct
  localparam aluOp_t aopOr    = 2'b11; // ori

  // result select
  localparam aluExt_t extBase = 2'b00;
  localparam aluExt_t extSltu = 2'b01;
  localparam aluExt_t extLui  = 2'b10;
  localparam aluExt_t extSll  = 2'b11;

endpackage

// File: hw/alu.sv
// ALU with extension results
// base ops plus sltu, sll and lui, picked by the result select
`timescale 1ns/1ps

module alu (
  input  mipsPkg::word_t    a,
  input  mipsPkg::word_t    b,
  input  mipsPkg::aluCtrl_t aluControl,
  input  mipsPkg::aluExt_t  aluExt,
  input  mipsPkg::shamt_t   shamt,
  input  mipsPkg::imm_t     imm,
  output mipsPkg::word_t    result,
  output logic              zero
);
  import mipsPkg::*;

  word_t baseResult;
  word_t sltuResult, sllResult, luiResult;

  // base operations
  always_comb begin
    case (aluControl)
      aluAnd:  baseResult = a & b;
      aluOr:   baseResult = a | b;
      aluAdd:  baseResult = a + b;
      aluXor:  baseResult = a ^ b;
      aluSub:  baseResult = a - b;
      aluSlt:  baseResult = {31'b0, $signed(a) < $signed(b)}; // signed compare
      default: baseResult = '0; // unused codes
    endcase
  end

  assign zero = (baseResult == '0); // branch compare uses base path only

  // extension results
  assign sltuResult = {31'b0, a < b};  // unsigned compare
  assign sllResult  = b << shamt;      // zeros shifted in
  assign luiResult  = {imm, 16'b0};    // upper half, low half cleared

  // result select
  always_comb begin
    case (aluExt)
      extSltu: result = sltuResult;
      extLui:  result = luiResult;
      extSll:  result = sllResult;
      default: result = baseResult;
    endcase
  end

endmodule

// File: hw/regFile.sv
// 32 x 32 register file
// two combinational read ports, one write port on the clock edge
`timescale 1ns/1ps

module regFile (
  input  logic              clk,
  input  logic              writeEnable,
  input  mipsPkg::regAddr_t readAddrA,
  input  mipsPkg::regAddr_t readAddrB,
  input  mipsPkg::regAddr_t writeAddr,
  input  mipsPkg::word_t    writeValue,
  output mipsPkg::word_t    readA,
  output mipsPkg::word_t    readB
);
  import mipsPkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (writeEnable && writeAddr != '0) begin // $0 never written
      regs[writeAddr] <= writeValue;
    end
  end

  // $0 reads as zero
  assign readA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// File: hw/mainDecoder.sv
// main decoder: opcode to datapath control signals
// unknown opcodes leave every control low
`timescale 1ns/1ps

module mainDecoder (
  input  mipsPkg::opcode_t op,
  output logic             regWrite,
  output logic             regDst,
  output logic             aluSrc,
  output logic             branch,
  output logic             memWrite,
  output logic             memToReg,
  output logic             jump,
  output mipsPkg::aluOp_t  aluOp
);
  import mipsPkg::*;

  // regWrite regDst aluSrc branch memWrite memToReg jump aluOp[1:0]
  logic [8:0] controls;

  assign {regWrite, regDst, aluSrc, branch,
          memWrite, memToReg, jump, aluOp} = controls;

  always_comb begin
    case (op)
      opRType: controls = {7'b1100000, aopFunct}; // rd <- rs op rt
      opLw:    controls = {7'b1010010, aopAdd};   // address add, load path
      opSw:    controls = {7'b0010100, aopAdd};
      opBeq:   controls = {7'b0001000, aopSub};   // compare by subtract
      opBne:   controls = {7'b0001000, aopSub};   // same as beq, polarity in controller
      opAddi:  controls = {7'b1010000, aopAdd};
      opJ:     controls = {7'b0000001, aopAdd};
      opOri:   controls = {7'b1010000, aopOr};
      opLui:   controls = {7'b1000000, aopAdd};   // base result discarded
      default: controls = '0;                     // inactive
    endcase
  end

endmodule

// File: hw/controller.sv
// control unit: main decode, ALU decode, result select, branch polarity
// memory and register writes are held off while in reset
`timescale 1ns/1ps

module controller (
  input  logic               rstN,
  input  logic               zero,
  input  mipsPkg::opcode_t   op,
  input  mipsPkg::funct_t    funct,
  output logic               memToReg,
  output logic               memWrite,
  output logic               pcSrc,
  output logic               aluSrc,
  output logic               regDst,
  output logic               regWrite,
  output logic               jump,
  output mipsPkg::aluCtrl_t  aluControl,
  output mipsPkg::aluExt_t   aluExt
);
  import mipsPkg::*;

  aluOp_t aluOp;
  logic   branch, rawMemWrite, rawRegWrite;
  logic   branchMet;

  mainDecoder md (
    .op(op), .regWrite(rawRegWrite), .regDst(regDst), .aluSrc(aluSrc),
    .branch(branch), .memWrite(rawMemWrite), .memToReg(memToReg),
    .jump(jump), .aluOp(aluOp)
  );

  always_comb begin
    case (aluOp)
      aopAdd:  aluControl = aluAdd;
      aopSub:  aluControl = aluSub;
      aopOr:   aluControl = aluOr;
      default: begin // R-type
        case (funct)
          fnAdd:   aluControl = aluAdd;
          fnSub:   aluControl = aluSub;
          fnAnd:   aluControl = aluAnd;
          fnOr:    aluControl = aluOr;
          fnXor:   aluControl = aluXor;
          fnSlt:   aluControl = aluSlt;
          fnSltu:  aluControl = aluSub; // base result unused, ext path wins
          default: aluControl = aluAdd; // sll and unknown funct
        endcase
      end
    endcase
  end

  always_comb begin
    aluExt = extBase; // everything else uses the base ALU
    if (op == opLui) aluExt = extLui;
    else if (op == opRType && funct == fnSltu) aluExt = extSltu;
    else if (op == opRType && funct == fnSll) aluExt = extSll;
  end

  assign branchMet = (op == opBne) ? ~zero : zero; // bne flips the compare
  assign pcSrc     = branch & branchMet;
  assign memWrite  = rawMemWrite & rstN; // no stores during reset
  assign regWrite  = rawRegWrite & rstN;

endmodule

// File: hw/datapath.sv
// single-cycle datapath
// PC register and next-PC logic, immediates, operand and write-back muxes
`timescale 1ns/1ps

module datapath #(
  parameter mipsPkg::word_t resetPc = '0
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              memToReg,
  input  logic              pcSrc,
  input  logic              aluSrc,
  input  logic              regDst,
  input  logic              regWrite,
  input  logic              jump,
  input  mipsPkg::aluCtrl_t aluControl,
  input  mipsPkg::aluExt_t  aluExt,
  input  mipsPkg::word_t    instr,
  input  mipsPkg::word_t    readData,
  output mipsPkg::word_t    pc,
  output mipsPkg::word_t    aluOut,
  output mipsPkg::word_t    writeData,
  output logic              zero,
  output mipsPkg::opcode_t  op,
  output mipsPkg::funct_t   funct
);
  import mipsPkg::*;

  word_t    pcNext, pcPlus4, pcBranch, pcJump;
  word_t    signImm, immExt;
  word_t    srcA, srcB, result;
  regAddr_t rs, rt, rd, writeReg;
  imm_t     imm;

  // instruction fields
  assign op    = instr[31:26];
  assign funct = instr[5:0];
  assign rs    = instr[25:21];
  assign rt    = instr[20:16];
  assign rd    = instr[15:11];
  assign imm   = instr[15:0];

  // PC register
  always_ff @(posedge clk) begin
    if (!rstN) pc <= resetPc; // reload every edge while in reset
    else pc <= pcNext;
  end

  // next-PC selection
  assign pcPlus4  = pc + 32'd4;
  assign pcBranch = pcPlus4 + {signImm[29:0], 2'b00}; // word offset
  assign pcJump   = {pcPlus4[31:28], instr[25:0], 2'b00}; // pseudo-direct

  always_comb begin
    if (jump) pcNext = pcJump;
    else if (pcSrc) pcNext = pcBranch;
    else pcNext = pcPlus4;
  end

  // immediates: ori zero-extends, others sign-extend
  assign signImm = {{16{imm[15]}}, imm};
  assign immExt  = (op == opOri) ? {16'b0, imm} : signImm;

  // register file
  assign writeReg = regDst ? rd : rt; // R-type writes rd
  assign result   = memToReg ? readData : aluOut;

  regFile rf (
    .clk(clk), .writeEnable(regWrite),
    .readAddrA(rs), .readAddrB(rt), .writeAddr(writeReg),
    .writeValue(result), .readA(srcA), .readB(writeData)
  );

  // ALU
  assign srcB = aluSrc ? immExt : writeData;

  alu alu0 (
    .a(srcA), .b(srcB), .aluControl(aluControl), .aluExt(aluExt),
    .shamt(instr[10:6]), .imm(imm), .result(aluOut), .zero(zero)
  );

endmodule

// File: hw/mipsCpu.sv
// single-cycle 32-bit MIPS core
// controller plus datapath; instruction and data memories sit outside
`timescale 1ns/1ps

module mipsCpu #(
  parameter mipsPkg::word_t resetPc = '0 // first fetch address
) (
  input  logic           clk,
  input  logic           rstN,
  input  mipsPkg::word_t instr,
  input  mipsPkg::word_t readData,
  output mipsPkg::word_t pc,
  output logic           memWrite,
  output mipsPkg::word_t aluOut,
  output mipsPkg::word_t writeData
);
  import mipsPkg::*;

  logic     memToReg, pcSrc, aluSrc, regDst, regWrite, jump, zero;
  aluCtrl_t aluControl;
  aluExt_t  aluExt;
  opcode_t  op;
  funct_t   funct;

  controller ctrl (
    .rstN(rstN), .zero(zero), .op(op), .funct(funct),
    .memToReg(memToReg), .memWrite(memWrite), .pcSrc(pcSrc),
    .aluSrc(aluSrc), .regDst(regDst), .regWrite(regWrite), .jump(jump),
    .aluControl(aluControl), .aluExt(aluExt)
  );

  datapath #(.resetPc(resetPc)) dp (
    .clk(clk), .rstN(rstN), .memToReg(memToReg), .pcSrc(pcSrc),
    .aluSrc(aluSrc), .regDst(regDst), .regWrite(regWrite), .jump(jump),
    .aluControl(aluControl), .aluExt(aluExt),
    .instr(instr), .readData(readData),
    .pc(pc), .aluOut(aluOut), .writeData(writeData),
    .zero(zero), .op(op), .funct(funct)
  );

endmodule

// File: tb/mipsChecker.sv
// store monitor for the MIPS core
// compares each store on the data port with the next expected record of the trace
`timescale 1ns/1ps

module mipsChecker (
  input  logic           clk,
  input  logic           rstN,
  input  logic           memWrite,
  input  mipsPkg::word_t aluOut,
  input  mipsPkg::word_t writeData,
  output int             mismatchCount,
  output int             extraCount,
  output int             storesSeen,
  output int             storesExpected,
  output logic           allSeen
);
  import mipsPkg::*;

  word_t      trace [256];
  word_t      expAddr, expData;
  logic [7:0] expIdx;
  int         mismatches = 0;
  int         extras = 0;
  int         seen = 0;
  int         expectedTotal;

  // behavior group of each expected store, in program order
  function automatic string storeTestName(input int idx);
    string name;
    if (idx < 6) name = "base R-type";
    else if (idx == 6) name = "sltu";
    else if (idx == 7) name = "ori";
    else if (idx < 11) name = "sll";
    else if (idx == 11) name = "lui";
    else if (idx == 12) name = "load/store round trip";
    else name = "branch and jump";
    return name;
  endfunction

  initial begin
    foreach (trace[i]) trace[i] = '0;
    $readmemh("tb/mipsTrace.txt", trace);
    expectedTotal = trace[1];
  end

  assign expIdx  = 8'h80 + {seen[6:0], 1'b0}; // address then data
  assign expAddr = trace[expIdx];
  assign expData = trace[expIdx + 8'd1];

  always @(posedge clk) begin
    if (memWrite) begin
      if (!rstN) begin
        $display("ERROR: store to address %h while reset is asserted", aluOut);
        extras <= extras + 1;
      end else if (seen >= expectedTotal) begin
        $display("ERROR: extra store to address %h with data %h", aluOut, writeData);
        extras <= extras + 1;
      end else begin
        if (aluOut !== expAddr || writeData !== expData) begin
          $display("MISMATCH %s store %0d: expected addr %h data %h, actual addr %h data %h",
                   storeTestName(seen), seen, expAddr, expData, aluOut, writeData);
          mismatches <= mismatches + 1;
        end
        seen <= seen + 1;
      end
    end
  end

  assign mismatchCount  = mismatches;
  assign extraCount     = extras;
  assign storesSeen     = seen;
  assign storesExpected = expectedTotal;
  assign allSeen        = (seen == expectedTotal);

endmodule

// File: tb/mipsCpu_assert.sv
// reset and PC assertions, bound into the MIPS core
`timescale 1ns/1ps

module mipsCpuAssert #(
  parameter mipsPkg::word_t resetPc = '0
) (
  input logic           clk,
  input logic           rstN,
  input logic           memWrite,
  input mipsPkg::word_t pc
);
  int assertFails = 0; // failures, summed by the testbench

  noStoreInReset: assert property (@(posedge clk) !rstN |-> !memWrite)
    else begin $error("store enabled while reset is asserted"); assertFails++; end

  firstFetch: assert property (@(posedge clk) $rose(rstN) |-> pc == resetPc)
    else begin $error("first fetch after reset not at the reset address"); assertFails++; end

  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else begin $error("pc not word aligned"); assertFails++; end

endmodule

bind mipsCpu mipsCpuAssert #(.resetPc(resetPc)) assertChecks (
  .clk(clk), .rstN(rstN), .memWrite(memWrite), .pc(pc)
);

// File: tb/mipsTb.sv
// testbench top for the single-cycle MIPS core
// clock, reset, instruction and data memory models, trace loading and run limit
`timescale 1ns/1ps

module mipsTb;
  import mipsPkg::*;

  localparam word_t      resetAddr   = 32'h1000_0000; // first fetch in a nonzero 256 MB region
  localparam int         resetCycles = 10;
  localparam logic [7:0] progBase    = 8'h10;         // program section in the trace

  logic  clk;
  logic  rstN;
  word_t instr, readData;
  word_t pc, aluOut, writeData;
  logic  memWrite;

  word_t trace [256]; // whole trace file image
  word_t dmem [64];   // word-addressed data memory
  word_t pcOffset;

  int    progWords;
  int    cycleLimit;
  int    cycleCount = 0;
  int    mismatchCount, extraCount, storesSeen, storesExpected;
  int    missingCount;
  int    errorTotal;
  logic  allSeen;
  logic  timedOut;

  mipsCpu #(.resetPc(resetAddr)) DUT (
    .clk(clk), .rstN(rstN), .instr(instr), .readData(readData),
    .pc(pc), .memWrite(memWrite), .aluOut(aluOut), .writeData(writeData)
  );

  mipsChecker storeCheck (
    .clk(clk), .rstN(rstN), .memWrite(memWrite),
    .aluOut(aluOut), .writeData(writeData),
    .mismatchCount(mismatchCount), .extraCount(extraCount),
    .storesSeen(storesSeen), .storesExpected(storesExpected),
    .allSeen(allSeen)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  // instruction memory read combinationally at pc
  assign pcOffset = pc - resetAddr;

  always_comb begin
    if (pcOffset < progWords * 4) instr = trace[progBase + {2'b00, pcOffset[7:2]}];
    else instr = '0; // nop past the program
  end

  // data memory read combinationally at aluOut
  assign readData = dmem[aluOut[7:2]];

  always @(posedge clk) begin
    if (!rstN) begin
      foreach (dmem[i]) dmem[i] <= '0; // cleared during reset
    end else if (memWrite) begin
      dmem[aluOut[7:2]] <= writeData;
    end
  end

  always @(posedge clk) cycleCount <= cycleCount + 1; // counts reset cycles too

  initial begin
    rstN = 1'b0;
    foreach (trace[i]) trace[i] = '0;
    $readmemh("tb/mipsTrace.txt", trace);
    progWords  = trace[0];
    cycleLimit = resetCycles + 4 * progWords + 20;

    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1; // first instruction runs next cycle

    while (!allSeen && cycleCount < cycleLimit) @(posedge clk);
    #1; // let the last edge settle in the checker

    timedOut     = !allSeen;
    missingCount = storesExpected - storesSeen;
    if (timedOut) begin
      $display("ERROR: timeout after %0d cycles, only %0d of %0d expected stores seen",
               cycleCount, storesSeen, storesExpected);
    end
    errorTotal = mismatchCount + extraCount + missingCount + DUT.assertChecks.assertFails;
    $display("errors: %0d mismatch, %0d extra, %0d missing, %0d assertion",
             mismatchCount, extraCount, missingCount, DUT.assertChecks.assertFails);
    if (errorTotal == 0 && !timedOut) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: tb/mipsTrace.txt
// MIPS core trace: @00 program word count, expected store count
// @10 program words, two per line; @80 expected stores as address then data
@00
00000028 00000010
@10
20010007 2002FFFD // addi $1,$0,7 ; addi $2,$0,-3
00221820 AC030000 // add $3,$1,$2 ; sw $3,0($0)
00221822 AC030004 // sub $3,$1,$2 ; sw $3,4($0)
00221824 AC030008 // and $3,$1,$2 ; sw $3,8($0)
00221825 AC03000C // or $3,$1,$2 ; sw $3,12($0)
00221826 AC030010 // xor $3,$1,$2 ; sw $3,16($0)
0041182A AC030014 // slt $3,$2,$1 ; sw $3,20($0)
0041182B AC030018 // sltu $3,$2,$1 ; sw $3,24($0)
34238000 AC03001C // ori $3,$1,0x8000 ; sw $3,28($0)
00011800 AC030020 // sll $3,$1,0 ; sw $3,32($0)
00011900 AC030024 // sll $3,$1,4 ; sw $3,36($0)
00011FC0 AC030028 // sll $3,$1,31 ; sw $3,40($0)
3C03ABCD AC03002C // lui $3,0xabcd ; sw $3,44($0)
8C04002C AC040030 // lw $4,44($0) ; sw $4,48($0)
10220001 AC010034 // beq $1,$2 not taken ; sw $1,52($0)
10210001 AC020038 // beq $1,$1 taken ; sw $2,56($0) skipped
14210001 AC02003C // bne $1,$1 not taken ; sw $2,60($0)
14220001 AC010040 // bne $1,$2 taken ; sw $1,64($0) skipped
08000026 AC010044 // j 0x98 ; sw $1,68($0) skipped
AC020048 08000027 // sw $2,72($0) ; j 0x9c to itself
@80
00000000 00000004 // add 7 + -3
00000004 0000000A // sub 7 - -3
00000008 00000005 // and
0000000C FFFFFFFF // or
00000010 FFFFFFFA // xor
00000014 00000001 // slt -3 < 7 signed
00000018 00000000 // sltu 0xfffffffd < 7 unsigned
0000001C 00008007 // ori zero-extended
00000020 00000007 // sll by 0
00000024 00000070 // sll by 4
00000028 80000000 // sll by 31
0000002C ABCD0000 // lui
00000030 ABCD0000 // reloaded word
00000034 00000007 // after beq not taken
0000003C FFFFFFFD // after bne not taken
00000048 FFFFFFFD // jump target

// File: sim.f
hw/mipsPkg.sv
hw/alu.sv
hw/regFile.sv
hw/mainDecoder.sv
hw/controller.sv
hw/datapath.sv
hw/mipsCpu.sv
tb/mipsChecker.sv
tb/mipsCpu_assert.sv
tb/mipsTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert
TOP      = mipsTb
FILELIST = sim.f
OBJDIR   = obj_dir
LOG      = sim.log
RUNOPTS  = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) $(RUNOPTS) 2>&1 | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
